// File: filelist.f
+incdir+rtl
rtl/relay_alu_pkg.sv
rtl/eight_bit_adder_unit.sv
rtl/logic_unit.sv
rtl/apb_alu_regs.sv
rtl/alu_execute_stage.sv
rtl/alu_writeback_stage.sv
rtl/relay_alu_top.sv
verification/relay_alu_assertions.sv
verification/relay_alu_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module relay_alu_tb -o relay_alu_sim
./obj_dir/relay_alu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

// File: verification/relay_alu_tb.sv
// Testbench for the relay ALU APB peripheral
// Random operands and commands from a fixed seed, checked against a
// reference model of registers B, C, A, D and the flags
`timescale 1ns/1ps
`include "relay_alu_defines.svh"

module relay_alu_tb
  import relay_alu_pkg::*;
();

  // About 1860 APB transfers over all tests
  localparam int PLANNED_TRANSFERS = 1860;
  localparam int TIMEOUT_CYCLES    = 40 * PLANNED_TRANSFERS + 500;

  logic      clk;
  logic      rst_n;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  integer seed;
  int     error_count;
  int     check_count;
  int     cycle_count;

  // Reference model state
  alu_data_t m_b;
  alu_data_t m_c;
  alu_data_t m_a;
  alu_data_t m_d;
  apb_data_t m_flags;

  relay_alu_top u_relay_alu_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #10 clk = ~clk;

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  task automatic check_value(input string name, input apb_data_t expected,
                             input apb_data_t actual);
    check_count++;
    assert (actual === expected) else begin
      $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
      error_count++;
    end
  endtask

  // Setup and access phases; outputs sampled on the falling edge
  task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err,
                              output int waits);
    waits = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) begin
      waits++;
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
  endtask

  task automatic bus_idle();
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_reg(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
    apb_data_t rdata;
    logic      err;
    int        waits;
    apb_transfer(1'b1, addr, data, rdata, err, waits);
    check_value($sformatf("pslverr write 0x%02h", addr), {31'b0, exp_err}, {31'b0, err});
    // Writes never wait
    check_value($sformatf("pready waits write 0x%02h", addr), 32'h0, waits);
  endtask

  task automatic read_expect(input string name, input apb_addr_t addr, input apb_data_t expected);
    apb_data_t rdata;
    logic      err;
    int        waits;
    apb_transfer(1'b0, addr, 32'h0, rdata, err, waits);
    check_value({name, " pslverr"}, 32'h0, {31'b0, err});
    check_value(name, expected, rdata);
    if (addr == `ALU_ADDR_B || addr == `ALU_ADDR_C) begin
      check_value({name, " pready waits"}, 32'h0, waits);
    end
  endtask

  task automatic check_all_registers();
    read_expect("B", `ALU_ADDR_B, {24'h0, m_b});
    read_expect("C", `ALU_ADDR_C, {24'h0, m_c});
    read_expect("A", `ALU_ADDR_A, {24'h0, m_a});
    read_expect("D", `ALU_ADDR_D, {24'h0, m_d});
    read_expect("FLAGS", `ALU_ADDR_FLAGS, m_flags);
  endtask

  task automatic read_dest(input alu_dest_e dest);
    if (dest == DEST_A) begin
      read_expect("A", `ALU_ADDR_A, {24'h0, m_a});
    end else begin
      read_expect("D", `ALU_ADDR_D, {24'h0, m_d});
    end
  endtask

  task automatic next_random(output apb_data_t value);
    value = $random(seed);
  endtask

  task automatic model_command(input alu_func_e func, input alu_dest_e dest);
    logic [8:0] sum;
    alu_data_t  res;
    logic       carry;
    sum   = 9'h0;
    res   = 8'h00;
    carry = 1'b0;
    case (func)
      FUNC_ADD: begin
        sum   = {1'b0, m_b} + {1'b0, m_c};
        res   = sum[7:0];
        carry = sum[8];
      end
      FUNC_INC: begin
        sum   = {1'b0, m_b} + 9'd1;
        res   = sum[7:0];
        carry = sum[8];
      end
      FUNC_AND: res = m_b & m_c;
      FUNC_OR:  res = m_b | m_c;
      FUNC_XOR: res = m_b ^ m_c;
      FUNC_NOT: res = ~m_b;
      FUNC_SHL: res = {m_b[6:0], m_b[7]};
      FUNC_CLR: res = 8'h00;
    endcase
    if (dest == DEST_A) begin
      m_a = res;
    end else begin
      m_d = res;
    end
    m_flags = 32'h0;
    m_flags[`ALU_FLAG_ZERO]  = (res == 8'h00);
    m_flags[`ALU_FLAG_CARRY] = carry;
    m_flags[`ALU_FLAG_SIGN]  = res[7];
  endtask

  task automatic issue_command(input alu_func_e func, input alu_dest_e dest);
    apb_data_t cmd;
    // Random upper bits, which the DUT ignores
    next_random(cmd);
    cmd[`ALU_CMD_FUNC_LSB +: `ALU_CMD_FUNC_W] = func;
    cmd[`ALU_CMD_DEST_BIT] = dest;
    write_reg(`ALU_ADDR_CMD, cmd, 1'b0);
    model_command(func, dest);
  endtask

  task automatic write_operands();
    apb_data_t rnd;
    next_random(rnd);
    write_reg(`ALU_ADDR_B, rnd, 1'b0);
    m_b = rnd[7:0];
    next_random(rnd);
    write_reg(`ALU_ADDR_C, rnd, 1'b0);
    m_c = rnd[7:0];
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Simulation timed out after %0d cycles before the tests finished", cycle_count);
    error_count++;
    finish_run();
  end

  initial begin
    apb_data_t rnd;
    apb_data_t rdata;
    logic      err;
    int        waits;
    seed        = 32'hed86;
    error_count = 0;
    check_count = 0;
    clk         = 1'b0;
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    m_b         = 8'h00;
    m_c         = 8'h00;
    m_a         = 8'h00;
    m_d         = 8'h00;
    m_flags     = 32'h0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    check_all_registers();

    for (int i = 0; i < 16; i++) begin
      write_operands();
      read_expect("B", `ALU_ADDR_B, {24'h0, m_b});
      read_expect("C", `ALU_ADDR_C, {24'h0, m_c});
    end

    for (int i = 0; i < 300; i++) begin
      write_operands();
      next_random(rnd);
      issue_command(alu_func_e'(rnd[2:0]), alu_dest_e'(rnd[3]));
      read_dest(alu_dest_e'(rnd[3]));
      read_expect("FLAGS", `ALU_ADDR_FLAGS, m_flags);
    end

    // Commands back to back, then every register
    for (int i = 0; i < 20; i++) begin
      write_operands();
      for (int k = 0; k < 3; k++) begin
        next_random(rnd);
        issue_command(alu_func_e'(rnd[2:0]), alu_dest_e'(rnd[3]));
      end
      check_all_registers();
    end

    // Read of A right behind the command stalls until writeback
    for (int i = 0; i < 20; i++) begin
      write_operands();
      next_random(rnd);
      issue_command(alu_func_e'(rnd[2:0]), DEST_A);
      read_expect("A", `ALU_ADDR_A, {24'h0, m_a});
    end

    next_random(rnd);
    write_reg(8'h18, rnd, 1'b1);
    write_reg(8'h02, rnd, 1'b1);
    write_reg(`ALU_ADDR_A, rnd, 1'b1);
    write_reg(`ALU_ADDR_D, rnd, 1'b1);
    write_reg(`ALU_ADDR_FLAGS, rnd, 1'b1);
    apb_transfer(1'b0, 8'h40, 32'h0, rdata, err, waits);
    check_value("pslverr read 0x40", 32'h1, {31'b0, err});
    check_value("pready waits read 0x40", 32'h0, waits);
    check_value("prdata upper bits read 0x40", 32'h0, {8'h0, rdata[31:8]});
    check_all_registers();

    bus_idle();
    finish_run();
  end

endmodule

// File: verification/relay_alu_assertions.sv
// Protocol and pipeline assertions for the relay ALU
// Bound into the top level, watches the APB handshake and stage valids
`timescale 1ns/1ps

module relay_alu_assertions
  import relay_alu_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        psel,
  input logic        penable,
  input logic        pready,
  input logic        pslverr,
  input alu_issue_t  issue,
  input alu_result_t result
);

  a_pready_in_access: assert property (
    @(posedge clk) disable iff (!rst_n) pready |-> (psel && penable)
  ) else $error("pready high outside an APB access cycle");

  a_issue_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) issue.valid |=> !issue.valid
  ) else $error("issue valid held longer than one cycle");

  // Execute stage takes exactly one cycle
  a_result_after_issue: assert property (
    @(posedge clk) disable iff (!rst_n) issue.valid |=> result.valid
  ) else $error("result valid missing one cycle after issue");

  a_result_from_issue: assert property (
    @(posedge clk) disable iff (!rst_n) result.valid |-> $past(issue.valid)
  ) else $error("result valid without an issue in the cycle before");

  a_slverr_with_ready: assert property (
    @(posedge clk) disable iff (!rst_n) pslverr |-> pready
  ) else $error("pslverr high without pready");

endmodule

bind relay_alu_top relay_alu_assertions u_assertions (
  .clk     (clk),
  .rst_n   (rst_n),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .issue   (issue),
  .result  (result)
);

// File: rtl/relay_alu_top.sv
// Relay computer ALU as an APB peripheral
// Register block with issue stage, execute stage and writeback stage
`timescale 1ns/1ps

module relay_alu_top
  import relay_alu_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr
);

  alu_issue_t  issue;
  alu_result_t result;
  alu_data_t   reg_a;
  alu_data_t   reg_d;
  alu_flags_t  flags;

  apb_alu_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .reg_a     (reg_a),
    .reg_d     (reg_d),
    .flags     (flags),
    .exec_busy (result.valid),
    .issue     (issue)
  );

  alu_execute_stage u_execute (
    .clk    (clk),
    .rst_n  (rst_n),
    .issue  (issue),
    .result (result)
  );

  alu_writeback_stage u_writeback (
    .clk    (clk),
    .rst_n  (rst_n),
    .result (result),
    .reg_a  (reg_a),
    .reg_d  (reg_d),
    .flags  (flags)
  );

endmodule

// File: rtl/alu_writeback_stage.sv
// Writeback stage of the relay ALU
// Owns destination registers A and D and the flag register.
// A valid result replaces the chosen register and all three flags.
`timescale 1ns/1ps

module alu_writeback_stage
  import relay_alu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  alu_result_t result,
  output alu_data_t   reg_a,
  output alu_data_t   reg_d,
  output alu_flags_t  flags
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_a <= '0;
      reg_d <= '0;
    end else if (result.valid) begin
      if (result.dest == DEST_A) begin
        reg_a <= result.result;
      end else begin
        reg_d <= result.result;
      end
    end
  end

  // Flags follow every command, whichever register it targets
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (result.valid) begin
      flags <= result.flags;
    end
  end

endmodule

// File: rtl/alu_execute_stage.sv
// Execute stage of the relay ALU
// Feeds the adder or the logic unit from the issued command, forms
// sign, carry and zero, and registers the result for writeback
`timescale 1ns/1ps

module alu_execute_stage
  import relay_alu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  alu_issue_t  issue,
  output alu_result_t result
);

  alu_data_t  adder_c;
  logic       carry_in;
  alu_data_t  adder_out;
  logic       adder_carry;
  alu_data_t  logic_out;
  logic       is_arith;
  alu_data_t  exec_data;
  alu_flags_t exec_flags;

  logic       valid_q;
  alu_dest_e  dest_q;
  alu_data_t  data_q;
  alu_flags_t flags_q;

  // INC is B plus zero with the carry in set
  always_comb begin
    adder_c  = issue.c;
    carry_in = 1'b0;
    if (issue.func == FUNC_INC) begin
      adder_c  = '0;
      carry_in = 1'b1;
    end
  end

  eight_bit_adder_unit u_adder (
    .b         (issue.b),
    .c         (adder_c),
    .carry_in  (carry_in),
    .adder_out (adder_out),
    .carry     (adder_carry)
  );

  logic_unit u_logic (
    .func      (issue.func),
    .b         (issue.b),
    .c         (issue.c),
    .logic_out (logic_out)
  );

  assign is_arith         = (issue.func == FUNC_ADD) || (issue.func == FUNC_INC);
  assign exec_data        = is_arith ? adder_out : logic_out;
  assign exec_flags.sign  = exec_data[7];
  assign exec_flags.carry = is_arith && adder_carry;
  assign exec_flags.zero  = (exec_data == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue.valid) begin
      dest_q  <= issue.dest;
      data_q  <= exec_data;
      flags_q <= exec_flags;
    end
  end

  assign result = '{valid: valid_q, dest: dest_q, result: data_q, flags: flags_q};

endmodule

// File: rtl/apb_alu_regs.sv
// APB register block of the relay ALU
// Holds operands B and C, decodes the register map and issues commands
// into the pipeline. Result reads wait while a command is in flight.
`timescale 1ns/1ps
`include "relay_alu_defines.svh"

module apb_alu_regs
  import relay_alu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  apb_addr_t  paddr,
  input  apb_data_t  pwdata,
  output apb_data_t  prdata,
  output logic       pready,
  output logic       pslverr,
  input  alu_data_t  reg_a,
  input  alu_data_t  reg_d,
  input  alu_flags_t flags,
  input  logic       exec_busy,
  output alu_issue_t issue
);

  apb_state_e state_q;
  apb_state_e state_d;
  alu_data_t  reg_b_q;
  alu_data_t  reg_c_q;

  // Issue stage
  logic       issue_valid_q;
  alu_func_e  issue_func_q;
  alu_dest_e  issue_dest_q;
  alu_data_t  issue_b_q;
  alu_data_t  issue_c_q;

  logic access;
  logic busy;
  logic addr_hit;
  logic addr_writable;
  logic result_read;
  logic wr_done;
  logic cmd_wr;

  always_comb begin
    addr_hit      = 1'b1;
    addr_writable = 1'b1;
    result_read   = 1'b0;
    case (paddr)
      `ALU_ADDR_B, `ALU_ADDR_C, `ALU_ADDR_CMD: begin
        addr_writable = 1'b1;
      end
      `ALU_ADDR_A, `ALU_ADDR_D, `ALU_ADDR_FLAGS: begin
        addr_writable = 1'b0;
        result_read   = !pwrite;
      end
      default: begin
        addr_hit      = 1'b0;
        addr_writable = 1'b0;
      end
    endcase
  end

  assign busy    = issue_valid_q || exec_busy;
  assign access  = psel && penable && (state_q != IDLE);
  // Wait states only for results still in the pipeline
  assign pready  = access && !(result_read && busy);
  assign pslverr = pready && (!addr_hit || (pwrite && !addr_writable));
  assign wr_done = pready && pwrite && addr_writable;
  assign cmd_wr  = wr_done && (paddr == `ALU_ADDR_CMD);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (psel && !penable) state_d = SETUP;
      end
      SETUP: begin
        if (!psel) state_d = IDLE;
        else if (penable) state_d = pready ? IDLE : ACCESS_WAIT;
      end
      ACCESS_WAIT: begin
        if (!psel || pready) state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q       <= IDLE;
      reg_b_q       <= '0;
      reg_c_q       <= '0;
      issue_valid_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      issue_valid_q <= cmd_wr;
      if (wr_done && paddr == `ALU_ADDR_B) reg_b_q <= pwdata[7:0];
      if (wr_done && paddr == `ALU_ADDR_C) reg_c_q <= pwdata[7:0];
    end
  end

  // Operands are sampled as they stand at the command edge
  always_ff @(posedge clk) begin
    if (cmd_wr) begin
      issue_func_q <= alu_func_e'(pwdata[`ALU_CMD_FUNC_LSB +: `ALU_CMD_FUNC_W]);
      issue_dest_q <= alu_dest_e'(pwdata[`ALU_CMD_DEST_BIT]);
      issue_b_q    <= reg_b_q;
      issue_c_q    <= reg_c_q;
    end
  end

  assign issue = '{
    valid: issue_valid_q,
    func:  issue_func_q,
    dest:  issue_dest_q,
    b:     issue_b_q,
    c:     issue_c_q
  };

  always_comb begin
    prdata = '0;
    case (paddr)
      `ALU_ADDR_B: prdata = apb_data_t'(reg_b_q);
      `ALU_ADDR_C: prdata = apb_data_t'(reg_c_q);
      `ALU_ADDR_A: prdata = apb_data_t'(reg_a);
      `ALU_ADDR_D: prdata = apb_data_t'(reg_d);
      `ALU_ADDR_FLAGS: begin
        prdata[`ALU_FLAG_ZERO]  = flags.zero;
        prdata[`ALU_FLAG_CARRY] = flags.carry;
        prdata[`ALU_FLAG_SIGN]  = flags.sign;
      end
      default: prdata = '0;
    endcase
  end

endmodule

// File: rtl/logic_unit.sv
// Logic unit of the relay ALU
// Bitwise AND, OR, XOR, NOT of B and circular left shift of B.
// Arithmetic codes and CLR give zero.
`timescale 1ns/1ps

module logic_unit
  import relay_alu_pkg::*;
(
  input  alu_func_e func,
  input  alu_data_t b,
  input  alu_data_t c,
  output alu_data_t logic_out
);

  always_comb begin
    case (func)
      FUNC_AND: begin
        logic_out = b & c;
      end
      FUNC_OR: begin
        logic_out = b | c;
      end
      FUNC_XOR: begin
        logic_out = b ^ c;
      end
      FUNC_NOT: begin
        logic_out = ~b;
      end
      FUNC_SHL: begin
        // Bit 7 wraps into bit 0
        logic_out = {b[6:0], b[7]};
      end
      default: begin
        logic_out = '0;
      end
    endcase
  end

endmodule

// File: rtl/eight_bit_adder_unit.sv
// Eight-bit ripple adder
// Chain of one-bit full adder cells, carry in at bit 0 and carry out
// from bit 7. Purely combinational.
`timescale 1ns/1ps

module eight_bit_adder_unit
  import relay_alu_pkg::*;
(
  input  alu_data_t b,
  input  alu_data_t c,
  input  logic      carry_in,
  output alu_data_t adder_out,
  output logic      carry
);

  // Carry chain, one entry more than the word
  logic [$bits(alu_data_t):0] chain;

  assign chain[0] = carry_in;

  genvar i;
  generate
    for (i = 0; i < $bits(alu_data_t); i++) begin : g_cell
      logic half_sum;

      assign half_sum     = b[i] ^ c[i];
      assign adder_out[i] = half_sum ^ chain[i];
      // Generate or propagate
      assign chain[i+1]   = (b[i] & c[i]) | (half_sum & chain[i]);
    end
  endgenerate

  assign carry = chain[$bits(alu_data_t)];

endmodule

// File: rtl/relay_alu_pkg.sv
// Relay ALU shared types
// Data words, function codes and the structs passed between pipeline stages
`include "relay_alu_defines.svh"

package relay_alu_pkg;

  typedef logic [7:0] alu_data_t;
  typedef logic [`ALU_APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  typedef enum logic [`ALU_CMD_FUNC_W-1:0] {
    FUNC_ADD = 3'd0,
    FUNC_INC = 3'd1,
    FUNC_AND = 3'd2,
    FUNC_OR  = 3'd3,
    FUNC_XOR = 3'd4,
    FUNC_NOT = 3'd5,
    FUNC_SHL = 3'd6,
    FUNC_CLR = 3'd7
  } alu_func_e;

  typedef enum logic {
    DEST_A = 1'b0,
    DEST_D = 1'b1
  } alu_dest_e;

  // Bit order matches the flag positions in the register map
  typedef struct packed {
    logic sign;
    logic carry;
    logic zero;
  } alu_flags_t;

  typedef struct packed {
    logic      valid;
    alu_func_e func;
    alu_dest_e dest;
    alu_data_t b;
    alu_data_t c;
  } alu_issue_t;

  typedef struct packed {
    logic       valid;
    alu_dest_e  dest;
    alu_data_t  result;
    alu_flags_t flags;
  } alu_result_t;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS_WAIT
  } apb_state_e;

endpackage

// File: rtl/relay_alu_defines.svh
// Relay ALU register map and field layout
// APB offsets, command word fields and flag bit positions
`ifndef RELAY_ALU_DEFINES_SVH
`define RELAY_ALU_DEFINES_SVH

`define ALU_APB_ADDR_W 8

// Register offsets
`define ALU_ADDR_B     8'h00
`define ALU_ADDR_C     8'h04
`define ALU_ADDR_CMD   8'h08
`define ALU_ADDR_A     8'h0C
`define ALU_ADDR_D     8'h10
`define ALU_ADDR_FLAGS 8'h14

// Command word layout
`define ALU_CMD_FUNC_LSB 0
`define ALU_CMD_FUNC_W   3
`define ALU_CMD_DEST_BIT 3

// Flag bits as seen on readback
`define ALU_FLAG_ZERO  0
`define ALU_FLAG_CARRY 1
`define ALU_FLAG_SIGN  2

`endif
